//--- common/key_pkg.sv
package key_pkg;

    // 2x6B + 2x4B + 2x2B fields plus one comparator bit per stage
    localparam int KEY_LEN = 197;

    // one table entry per tenant
    localparam int TABLE_DEPTH = 16;

    // key layout from the top:
    //   6B field, 6B field, 4B field, 4B field, 2B field, 2B field, cmp[4:0]
    // stage s owns comparator bit 4-s
    typedef logic [KEY_LEN-1:0] key_t;

    // a one in the mask clears that key bit
    typedef logic [KEY_LEN-1:0] mask_t;

    typedef logic [$clog2(TABLE_DEPTH)-1:0] tenant_t;

    // container indices picked for each key field, top field first
    typedef struct packed {
        logic [2:0] idx_6b_0;
        logic [2:0] idx_6b_1;
        logic [2:0] idx_4b_0;
        logic [2:0] idx_4b_1;
        logic [2:0] idx_2b_0;
        logic [2:0] idx_2b_1;
    } key_off_t;

    typedef enum logic [1:0] {
        GT     = 2'd0,
        GE     = 2'd1,
        EQ     = 2'd2,
        ALWAYS = 2'd3
    } cmp_mode_t;

endpackage

//--- common/phv_pkg.sv
package phv_pkg;

    // full packet header vector
    localparam int PHV_LEN = 1124;

    // containers per size class
    localparam int NUM_CONT = 8;

    // compare operations carried in the PHV, one per stage
    localparam int NUM_OPS = 5;

    // top bit of compare operation 0, ops 1..4 follow below it
    localparam int COM_OP_TOP = 355;

    // tenant id is vlan id bits 7:4 inside the metadata
    localparam int TENANT_LSB = 133;

    typedef logic [47:0] cont_6b_t;
    typedef logic [31:0] cont_4b_t;
    typedef logic [15:0] cont_2b_t;

    typedef logic [PHV_LEN-1:0] phv_t;

    // container area, top of the PHV, highest index first
    typedef struct packed {
        cont_6b_t [NUM_CONT-1:0] cont_6b;
        cont_4b_t [NUM_CONT-1:0] cont_4b;
        cont_2b_t [NUM_CONT-1:0] cont_2b;
    } phv_fields_t;

    // container size class in an operand reference, value 3 is unused
    typedef enum logic [1:0] {
        CONT_2B = 2'd0,
        CONT_4B = 2'd1,
        CONT_6B = 2'd2
    } cont_sel_t;

    // operand field holds an immediate, or {type, index} in its low 5 bits
    typedef struct packed {
        logic [1:0] cmp_mode;
        logic       op1_imm;
        logic [7:0] op1;
        logic       op2_imm;
        logic [7:0] op2;
    } com_op_t;

endpackage

//--- common/unpack_if.sv
`timescale 1ns/1ps

interface unpack_if;
    import phv_pkg::*;
    import key_pkg::*;

    // one-cycle strobe, everything below is valid with it
    logic        load;
    phv_t        phv;
    phv_fields_t fields;
    logic [7:0]  op_a;
    logic [7:0]  op_b;
    cmp_mode_t   cmp_mode;

    // result leaves at the end of this cycle
    logic        done;

    modport producer (
        output load, phv, fields, op_a, op_b, cmp_mode,
        input  done
    );

    modport consumer (
        input  load, phv, fields, op_a, op_b, cmp_mode,
        output done
    );

endinterface

//--- key_extract/key_assembler.sv
`timescale 1ns/1ps

module key_assembler #(
    parameter int STAGE_ID = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    unpack_if.consumer         cs,
    input  key_pkg::key_off_t  key_off,
    input  key_pkg::mask_t     key_mask,
    input  logic               ready_in,
    output phv_pkg::phv_t      phv_out,
    output logic               phv_valid_out,
    output key_pkg::key_t      key_out_masked,
    output logic               key_valid_out,
    output key_pkg::mask_t     key_mask_out
);
    import phv_pkg::*;
    import key_pkg::*;

    // stage s owns comparator bit 4-s
    localparam int CMP_BIT = NUM_OPS - 1 - STAGE_ID;

    logic               cmp_hit;
    logic [NUM_OPS-1:0] cmp_bits;
    key_t               key_next;
    key_t               key_q;
    mask_t              mask_q;
    phv_t               phv_q;
    logic               pending_q;
    logic               valid_q;
    logic               emit;

    always_comb begin
        case (cs.cmp_mode)
            GT:      cmp_hit = (cs.op_a > cs.op_b);
            GE:      cmp_hit = (cs.op_a >= cs.op_b);
            EQ:      cmp_hit = (cs.op_a == cs.op_b);
            default: cmp_hit = 1'b1;
        endcase
    end

    // bits of the other stages stay zero
    always_comb begin
        cmp_bits          = '0;
        cmp_bits[CMP_BIT] = cmp_hit;
    end

    assign key_next = {cs.fields.cont_6b[key_off.idx_6b_0],
                       cs.fields.cont_6b[key_off.idx_6b_1],
                       cs.fields.cont_4b[key_off.idx_4b_0],
                       cs.fields.cont_4b[key_off.idx_4b_1],
                       cs.fields.cont_2b[key_off.idx_2b_0],
                       cs.fields.cont_2b[key_off.idx_2b_1],
                       cmp_bits};

    // result waits here until downstream is ready
    assign emit    = pending_q & ready_in;
    assign cs.done = emit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= emit;
            if (cs.load) begin
                pending_q <= 1'b1;
            end else if (emit) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs.load) begin
            key_q  <= key_next;
            mask_q <= key_mask;
            phv_q  <= cs.phv;
        end
    end

    // outputs only move with the valid pulse
    always_ff @(posedge clk) begin
        if (emit) begin
            phv_out        <= phv_q;
            key_out_masked <= key_q & ~mask_q;
            key_mask_out   <= mask_q;
        end
    end

    assign phv_valid_out = valid_q;
    assign key_valid_out = valid_q;

endmodule

//--- key_extract/key_extract.sv
`timescale 1ns/1ps

module key_extract #(
    parameter int STAGE_ID = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  phv_pkg::phv_t      phv_in,
    input  logic               phv_valid_in,
    output logic               ready_out,
    output phv_pkg::phv_t      phv_out,
    output logic               phv_valid_out,
    output key_pkg::key_t      key_out_masked,
    output logic               key_valid_out,
    output key_pkg::mask_t     key_mask_out,
    input  logic               ready_in,
    input  logic               off_wr_en,
    input  logic               mask_wr_en,
    input  key_pkg::tenant_t   wr_index,
    input  key_pkg::key_off_t  off_wr_data,
    input  key_pkg::mask_t     mask_wr_data
);
    import key_pkg::*;

    logic     rd_en;
    tenant_t  rd_addr;
    key_off_t off_rd_data;
    mask_t    mask_rd_data;

    unpack_if u_if ();

    phv_unpack #(
        .STAGE_ID (STAGE_ID)
    ) u_unpack (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .ready_out    (ready_out),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .up           (u_if.producer)
    );

    // both tables are indexed by the same tenant id
    tenant_table #(
        .entry_t (key_off_t),
        .DEPTH   (TABLE_DEPTH)
    ) u_off_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (off_wr_en),
        .wr_addr (wr_index),
        .wr_data (off_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (off_rd_data)
    );

    tenant_table #(
        .entry_t (mask_t),
        .DEPTH   (TABLE_DEPTH)
    ) u_mask_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (mask_wr_en),
        .wr_addr (wr_index),
        .wr_data (mask_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (mask_rd_data)
    );

    key_assembler #(
        .STAGE_ID (STAGE_ID)
    ) u_assembler (
        .clk            (clk),
        .rst_n          (rst_n),
        .cs             (u_if.consumer),
        .key_off        (off_rd_data),
        .key_mask       (mask_rd_data),
        .ready_in       (ready_in),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out)
    );

endmodule

//--- key_extract/phv_unpack.sv
`timescale 1ns/1ps

module phv_unpack #(
    parameter int STAGE_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  phv_pkg::phv_t     phv_in,
    input  logic              phv_valid_in,
    output logic              ready_out,
    output logic              rd_en,
    output key_pkg::tenant_t  rd_addr,
    unpack_if.producer        up
);
    import phv_pkg::*;
    import key_pkg::*;

    // top bit of the compare operation owned by this stage
    localparam int OP_TOP = COM_OP_TOP - STAGE_ID * $bits(com_op_t);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t      state_q;
    logic        accept;
    logic        issued_q;
    logic        load_q;
    phv_t        phv_q;
    phv_fields_t fields_q;
    com_op_t     op_q;
    logic [7:0]  op_a_q;
    logic [7:0]  op_b_q;

    // immediate, or low byte of the referenced container
    function automatic logic [7:0] pick_operand(input logic imm, input logic [7:0] sel,
                                                input phv_fields_t f);
        logic [7:0] val;
        if (imm) begin
            val = sel;
        end else begin
            case (cont_sel_t'(sel[4:3]))
                CONT_6B: val = f.cont_6b[sel[2:0]][7:0];
                CONT_4B: val = f.cont_4b[sel[2:0]][7:0];
                CONT_2B: val = f.cont_2b[sel[2:0]][7:0];
                default: val = '0;
            endcase
        end
        return val;
    endfunction

    assign ready_out = (state_q == IDLE);
    assign accept    = phv_valid_in & ready_out;

    // table read goes out in the accepting cycle
    assign rd_en   = accept;
    assign rd_addr = phv_in[TENANT_LSB +: $bits(tenant_t)];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            issued_q <= 1'b0;
            load_q   <= 1'b0;
        end else begin
            issued_q <= accept;
            load_q   <= issued_q;
            case (state_q)
                IDLE: if (accept) state_q <= BUSY;
                BUSY: if (up.done) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // payload is held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_q    <= phv_in;
            fields_q <= phv_fields_t'(phv_in[PHV_LEN-1 -: $bits(phv_fields_t)]);
            op_q     <= com_op_t'(phv_in[OP_TOP -: $bits(com_op_t)]);
        end
        if (issued_q) begin
            op_a_q <= pick_operand(op_q.op1_imm, op_q.op1, fields_q);
            op_b_q <= pick_operand(op_q.op2_imm, op_q.op2, fields_q);
        end
    end

    assign up.load     = load_q;
    assign up.phv      = phv_q;
    assign up.fields   = fields_q;
    assign up.op_a     = op_a_q;
    assign up.op_b     = op_b_q;
    assign up.cmp_mode = cmp_mode_t'(op_q.cmp_mode);

endmodule

//--- key_extract/tenant_table.sv
`timescale 1ns/1ps

module tenant_table #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = key_pkg::TABLE_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  entry_t                   wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output entry_t                   rd_data
);

    // all entries start out as zero
    entry_t mem [DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // same-entry write and read in one cycle returns the old entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- tb.f
common/phv_pkg.sv
common/key_pkg.sv
common/unpack_if.sv
key_extract/tenant_table.sv
key_extract/phv_unpack.sv
key_extract/key_assembler.sv
key_extract/key_extract.sv
verif/key_extract_chk.sv
verif/tb_key_extract.sv

//--- verif/key_extract_chk.sv
`timescale 1ns/1ps

module key_extract_chk (
    input logic clk,
    input logic rst_n,
    input logic phv_valid_in,
    input logic ready_out,
    input logic phv_valid_out,
    input logic key_valid_out,
    input logic ready_in
);

    // number of assertion failures so far
    int fail_count = 0;

    // both valid outputs describe the same result
    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == key_valid_out)
        else begin
            fail_count++;
            $error("phv_valid_out and key_valid_out differ");
        end

    a_one_cycle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out |=> !phv_valid_out)
        else begin
            fail_count++;
            $error("valid pulse longer than one cycle");
        end

    // downstream must have been ready in the cycle before the pulse
    a_ready_before_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(phv_valid_out) |-> $past(ready_in))
        else begin
            fail_count++;
            $error("valid rose without ready_in in the cycle before");
        end

    a_busy_until_emit: assert property (@(posedge clk) disable iff (!rst_n)
        (phv_valid_in && ready_out) |=> (!ready_out until phv_valid_out))
        else begin
            fail_count++;
            $error("ready_out rose before the result was emitted");
        end

endmodule

bind key_extract key_extract_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .phv_valid_in  (phv_valid_in),
    .ready_out     (ready_out),
    .phv_valid_out (phv_valid_out),
    .key_valid_out (key_valid_out),
    .ready_in      (ready_in)
);

//--- verif/tb_key_extract.sv
`timescale 1ns/1ps

module tb_key_extract;
    import phv_pkg::*;
    import key_pkg::*;

    localparam int STAGE_ID = 2;
    localparam int NUM_ROWS = 19;
    localparam int OP_TOP   = COM_OP_TOP - STAGE_ID * $bits(com_op_t);
    // lowest bit of container 0 in each size class
    localparam int LSB_6B = PHV_LEN - NUM_CONT * $bits(cont_6b_t);
    localparam int LSB_4B = LSB_6B - NUM_CONT * $bits(cont_4b_t);
    localparam int LSB_2B = LSB_4B - NUM_CONT * $bits(cont_2b_t);

    typedef struct {
        tenant_t    tenant;
        cmp_mode_t  mode;
        logic       op1_imm;
        logic [7:0] op1;
        logic       op2_imm;
        logic [7:0] op2;
        int         stall;
        logic       rewrite;
    } row_t;

    logic     clk;
    logic     rst_n;
    phv_t     phv_in;
    logic     phv_valid_in;
    logic     ready_out;
    phv_t     phv_out;
    logic     phv_valid_out;
    key_t     key_out_masked;
    logic     key_valid_out;
    mask_t    key_mask_out;
    logic     ready_in;
    logic     off_wr_en;
    logic     mask_wr_en;
    tenant_t  wr_index;
    key_off_t off_wr_data;
    mask_t    mask_wr_data;

    row_t     rows [NUM_ROWS];
    key_off_t off_tab [TABLE_DEPTH];
    mask_t    mask_tab [TABLE_DEPTH];
    int       error_count;
    int       cycle_count;
    int       cycle_limit;

    key_extract #(
        .STAGE_ID (STAGE_ID)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out),
        .ready_in       (ready_in),
        .off_wr_en      (off_wr_en),
        .mask_wr_en     (mask_wr_en),
        .wr_index       (wr_index),
        .off_wr_data    (off_wr_data),
        .mask_wr_data   (mask_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // tenant, mode, op1 imm/sel, op2 imm/sel, ready_in low cycles, rewrite entry first
    task automatic load_rows();
        rows[0]  = '{4'd0,  GT,     1'b1, 8'h20, 1'b1, 8'h10, 0, 1'b0};
        rows[1]  = '{4'd1,  GT,     1'b1, 8'h10, 1'b1, 8'h20, 2, 1'b0};
        rows[2]  = '{4'd2,  GE,     1'b1, 8'h33, 1'b1, 8'h33, 4, 1'b0};
        rows[3]  = '{4'd3,  GE,     1'b1, 8'h03, 1'b1, 8'h02, 0, 1'b0};
        rows[4]  = '{4'd4,  EQ,     1'b1, 8'h55, 1'b1, 8'h55, 5, 1'b0};
        rows[5]  = '{4'd5,  EQ,     1'b0, 8'h13, 1'b1, 8'h00, 0, 1'b0};
        rows[6]  = '{4'd6,  ALWAYS, 1'b1, 8'h00, 1'b1, 8'hff, 1, 1'b0};
        rows[7]  = '{4'd7,  GT,     1'b0, 8'h0d, 1'b0, 8'h01, 6, 1'b0};
        rows[8]  = '{4'd8,  EQ,     1'b0, 8'h02, 1'b0, 8'h02, 0, 1'b0};
        rows[9]  = '{4'd9,  GE,     1'b0, 8'h1c, 1'b1, 8'h01, 3, 1'b0};
        rows[10] = '{4'd10, EQ,     1'b1, 8'h07, 1'b0, 8'h08, 0, 1'b0};
        rows[11] = '{4'd11, GE,     1'b0, 8'h17, 1'b0, 8'h17, 1, 1'b0};
        rows[12] = '{4'd12, GT,     1'b1, 8'hff, 1'b0, 8'h07, 0, 1'b0};
        rows[13] = '{4'd13, ALWAYS, 1'b0, 8'h0a, 1'b0, 8'h15, 2, 1'b0};
        rows[14] = '{4'd14, EQ,     1'b1, 8'h13, 1'b1, 8'h12, 0, 1'b0};
        rows[15] = '{4'd15, GE,     1'b1, 8'h00, 1'b1, 8'hff, 7, 1'b0};
        rows[16] = '{4'd4,  GT,     1'b1, 8'h80, 1'b1, 8'h80, 0, 1'b1};
        rows[17] = '{4'd5,  EQ,     1'b0, 8'h13, 1'b1, 8'h00, 0, 1'b0};
        rows[18] = '{4'd4,  GE,     1'b1, 8'h40, 1'b1, 8'h40, 2, 1'b0};
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run();
        error_count++;
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_key(input string name, input key_t exp, input key_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input mask_t exp, input mask_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_phv(input string name, input phv_t exp, input phv_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic phv_t rand_wide();
        phv_t v;
        v = '0;
        repeat ((PHV_LEN + 31) / 32) begin
            v = (v << 32) | phv_t'($urandom());
        end
        return v;
    endfunction

    function automatic key_off_t rand_off();
        logic [31:0] r;
        r = $urandom();
        return r[$bits(key_off_t)-1:0];
    endfunction

    // comparator bits stay unmasked so the compare result reaches the output
    function automatic mask_t rand_mask();
        phv_t  a;
        mask_t m;
        a = rand_wide();
        m = a[KEY_LEN-1:0];
        m[NUM_OPS-1:0] = '0;
        return m;
    endfunction

    function automatic phv_t make_phv(input row_t row);
        phv_t    p;
        com_op_t op;
        p = rand_wide();
        op.cmp_mode = row.mode;
        op.op1_imm  = row.op1_imm;
        op.op1      = row.op1;
        op.op2_imm  = row.op2_imm;
        op.op2      = row.op2;
        p[OP_TOP -: $bits(com_op_t)]       = op;
        p[TENANT_LSB +: $bits(tenant_t)] = row.tenant;
        return p;
    endfunction

    // operand from the raw PHV bits, type 3 reads as zero
    function automatic logic [7:0] ref_operand(input phv_t p, input logic imm,
                                               input logic [7:0] sel);
        if (imm) begin
            return sel;
        end
        case (sel[4:3])
            2'd2:    return p[LSB_6B + 48 * sel[2:0] +: 8];
            2'd1:    return p[LSB_4B + 32 * sel[2:0] +: 8];
            2'd0:    return p[LSB_2B + 16 * sel[2:0] +: 8];
            default: return 8'h00;
        endcase
    endfunction

    function automatic key_t ref_key(input phv_t p, input key_off_t off);
        com_op_t            op;
        logic [7:0]         a;
        logic [7:0]         b;
        logic               hit;
        logic [NUM_OPS-1:0] cmp;
        op = p[OP_TOP -: $bits(com_op_t)];
        a  = ref_operand(p, op.op1_imm, op.op1);
        b  = ref_operand(p, op.op2_imm, op.op2);
        case (op.cmp_mode)
            2'd0:    hit = a > b;
            2'd1:    hit = a >= b;
            2'd2:    hit = a == b;
            default: hit = 1'b1;
        endcase
        cmp = '0;
        cmp[NUM_OPS - 1 - STAGE_ID] = hit;
        return {p[LSB_6B + 48 * off.idx_6b_0 +: 48], p[LSB_6B + 48 * off.idx_6b_1 +: 48],
                p[LSB_4B + 32 * off.idx_4b_0 +: 32], p[LSB_4B + 32 * off.idx_4b_1 +: 32],
                p[LSB_2B + 16 * off.idx_2b_0 +: 16], p[LSB_2B + 16 * off.idx_2b_1 +: 16],
                cmp};
    endfunction

    task automatic write_entry(input tenant_t idx, input key_off_t off, input mask_t m);
        wr_index     = idx;
        off_wr_data  = off;
        mask_wr_data = m;
        off_wr_en    = 1'b1;
        mask_wr_en   = 1'b1;
        next_cycle();
        off_wr_en    = 1'b0;
        mask_wr_en   = 1'b0;
        off_tab[idx]  = off;
        mask_tab[idx] = m;
    endtask

    task automatic run_row(input int r);
        phv_t  phv;
        key_t  exp_key;
        mask_t exp_mask;
        int    exp_edge;
        int    edge_n;
        int    low_left;
        if (rows[r].rewrite) begin
            write_entry(rows[r].tenant, rand_off(), rand_mask());
        end
        phv      = make_phv(rows[r]);
        exp_mask = mask_tab[rows[r].tenant];
        exp_key  = ref_key(phv, off_tab[rows[r].tenant]) & ~exp_mask;
        exp_edge = (rows[r].stall + 1 > 3) ? rows[r].stall + 1 : 3;
        if (!ready_out) begin
            report_error($sformatf("row %0d: ready_out low before the PHV was offered", r));
        end
        phv_in       = phv;
        phv_valid_in = 1'b1;
        ready_in     = 1'b1;
        next_cycle();
        if (ready_out) begin
            report_error($sformatf("row %0d: PHV was not accepted", r));
        end
        // another PHV waits at the input the whole time
        phv_in   = rand_wide();
        low_left = rows[r].stall;
        edge_n   = 0;
        while (!phv_valid_out) begin
            if (edge_n >= exp_edge) begin
                report_error($sformatf("row %0d: no valid pulse by edge %0d", r, exp_edge));
            end
            if (ready_out) begin
                report_error($sformatf("row %0d: ready_out rose before the result left", r));
            end
            ready_in = (low_left == 0);
            if (low_left > 0) begin
                low_left--;
            end
            next_cycle();
            edge_n++;
        end
        if (edge_n != exp_edge) begin
            report_error($sformatf("row %0d: valid pulse at edge %0d instead of edge %0d",
                                   r, edge_n, exp_edge));
        end
        if (!key_valid_out || !ready_out) begin
            report_error($sformatf("row %0d: key_valid_out or ready_out low at the pulse", r));
        end
        check_phv("phv_out", phv, phv_out);
        check_key("key_out_masked", exp_key, key_out_masked);
        check_mask("key_mask_out", exp_mask, key_mask_out);
        phv_valid_in = 1'b0;
        ready_in     = 1'b1;
        next_cycle();
        if (phv_valid_out || key_valid_out) begin
            report_error($sformatf("row %0d: valid pulse longer than one cycle", r));
        end
        if (!ready_out) begin
            report_error($sformatf("row %0d: the waiting PHV was taken", r));
        end
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
            if (u_dut.u_chk.fail_count != 0) begin
                report_error("a handshake assertion failed");
            end
        end
        report_error($sformatf("timeout, run took more than %0d cycles", cycle_limit));
    end

    initial begin
        int max_stall;
        int i;
        void'($urandom(25));
        error_count  = 0;
        cycle_limit  = 0;
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        ready_in     = 1'b1;
        off_wr_en    = 1'b0;
        mask_wr_en   = 1'b0;
        wr_index     = '0;
        off_wr_data  = '0;
        mask_wr_data = '0;
        load_rows();
        max_stall = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].stall > max_stall) begin
                max_stall = rows[i].stall;
            end
        end
        cycle_limit = NUM_ROWS * (8 + max_stall) + 64;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        if (!ready_out || phv_valid_out || key_valid_out) begin
            report_error("handshake outputs not in their reset state");
        end
        for (i = 0; i < TABLE_DEPTH; i++) begin
            write_entry(tenant_t'(i), rand_off(), rand_mask());
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        if (error_count == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
